// ==== map_pkg.sv ====
`default_nettype none

package map_pkg;

    // 18-bit byte address, top two bits pick a 64 KiB region
    localparam int ADDR_W = 18;

    typedef enum logic [1:0] {
        REG_RAM  = 2'd0,
        REG_MMIO = 2'd1,
        REG_ROM  = 2'd2,
        // unmapped, reads zero and swallows writes
        REG_NONE = 2'd3
    } region_e;

    // one select per storage or peripheral block
    typedef struct packed {
        logic ram;
        logic mmio;
        logic rom;
    } sel_t;

endpackage

`default_nettype wire

// ==== bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    import map_pkg::*;

    typedef enum logic {
        OWN_CPU = 1'b0,
        OWN_DBG = 1'b1
    } owner_e;

    // RAM and ROM see a word index
    typedef struct packed {
        region_e             region;
        logic [ADDR_W-5:0]   index;
        logic [1:0]          byte_off;
    } mem_addr_t;

    // MMIO sees a channel number in address bits 3..2
    typedef struct packed {
        region_e             region;
        logic [ADDR_W-7:0]   unused;
        logic [1:0]          channel;
        logic [1:0]          byte_off;
    } mmio_addr_t;

    typedef union packed {
        mem_addr_t  mem;
        mmio_addr_t mmio;
    } bus_addr_u;

    typedef struct packed {
        bus_addr_u   addr;
        logic [31:0] wdata;
        // all zero means a read
        logic [3:0]  wstrb;
        owner_e      owner;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cpu_run,
    input  logic     cpu_valid,
    input  logic     dbg_valid,
    input  bus_req_t cpu_req,
    input  bus_req_t dbg_req,
    output bus_req_t gnt_req,
    output logic     accept,
    output owner_e   busy_owner
);

    logic   busy;
    logic   cpu_eligible;
    owner_e grant_owner;

    // a halted CPU cannot reach the bus
    assign cpu_eligible = cpu_valid && cpu_run;

    // only an idle fabric takes a new access
    assign accept = !busy && (dbg_valid || cpu_eligible);

    // debug port always wins
    assign grant_owner = dbg_valid ? OWN_DBG : OWN_CPU;

    always_comb begin
        if (grant_owner == OWN_DBG) begin
            gnt_req = dbg_req;
        end else begin
            gnt_req = cpu_req;
        end
        gnt_req.owner = grant_owner;
    end

    // busy covers the ready cycle and the owner is kept for routing the answer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            busy_owner <= OWN_CPU;
        end else begin
            busy <= accept;
            if (accept) begin
                busy_owner <= grant_owner;
            end
        end
    end

    // at most one accept every two cycles
    a_no_accept_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        accept |=> !accept
    ) else $error("bus_arbiter: accept while busy");

endmodule

`default_nettype wire

// ==== bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_decode
    import map_pkg::*, bus_pkg::*;
(
    input  bus_req_t   gnt_req,
    input  logic       accept,
    output sel_t       sel,
    output logic       ram_we,
    output logic       rom_we,
    output logic       mmio_we,
    output logic [1:0] mmio_channel
);

    region_e region;
    logic    is_write;

    // same address word, two readings
    assign region       = gnt_req.addr.mem.region;
    assign mmio_channel = gnt_req.addr.mmio.channel;

    assign is_write = |gnt_req.wstrb;

    // REG_NONE raises no select, so the access is acked with zero data
    assign sel.ram  = accept && (region == REG_RAM);
    assign sel.mmio = accept && (region == REG_MMIO);
    assign sel.rom  = accept && (region == REG_ROM);

    assign ram_we  = sel.ram && is_write;
    assign mmio_we = sel.mmio && is_write;

    // ROM is read-only for the CPU, the debug port loads it
    assign rom_we = sel.rom && is_write && (gnt_req.owner == OWN_DBG);

    always_comb begin
        a_sel_onehot: assert ($onehot0(sel))
            else $error("bus_decode: more than one region selected");
    end

endmodule

`default_nettype wire

// ==== sram_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_bank
    import map_pkg::*;
#(
    parameter int DEPTH_WORDS = 1024
) (
    input  logic              clk,
    input  logic              cs,
    input  logic              we,
    input  logic [3:0]        wstrb,
    input  logic [ADDR_W-5:0] index,
    input  logic [31:0]       wdata,
    output logic [31:0]       rdata
);

    localparam int AW = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;

    logic [31:0] mem [DEPTH_WORDS];
    logic [AW-1:0] word_addr;

    // index wraps around the physical depth
    assign word_addr = AW'(index % DEPTH_WORDS);

    // byte lanes written under their strobe
    always_ff @(posedge clk) begin
        if (cs && we) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    mem[word_addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // zero when idle keeps the shared OR bus clean
    always_ff @(posedge clk) begin
        if (cs) begin
            rdata <= mem[word_addr];
        end else begin
            rdata <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== pwm_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_bank #(
    parameter int PWM_CHANNELS = 3
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cs,
    input  logic                    we,
    input  logic [1:0]              channel,
    input  logic [31:0]             wdata,
    output logic [31:0]             rdata,
    output logic [PWM_CHANNELS-1:0] pwm_out
);

    logic [7:0] duty [PWM_CHANNELS];
    logic [7:0] counter;
    logic [7:0] ch_duty;

    // one shared period of 256 clocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counter <= '0;
        end else begin
            counter <= counter + 8'd1;
        end
    end

    // channels past PWM_CHANNELS have no register, writes drop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < PWM_CHANNELS; k++) begin
                duty[k] <= '0;
            end
        end else if (cs && we) begin
            for (int k = 0; k < PWM_CHANNELS; k++) begin
                if (channel == 2'(k)) begin
                    duty[k] <= wdata[7:0];
                end
            end
        end
    end

    // readback mux, missing channels read zero
    always_comb begin
        ch_duty = '0;
        for (int k = 0; k < PWM_CHANNELS; k++) begin
            if (channel == 2'(k)) begin
                ch_duty = duty[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs) begin
            rdata <= {24'h0, ch_duty};
        end else begin
            rdata <= '0;
        end
    end

    // duty d gives d high cycles per period
    for (genvar k = 0; k < PWM_CHANNELS; k++) begin : g_out
        assign pwm_out[k] = counter < duty[k];
    end

endmodule

`default_nettype wire

// ==== bus_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_result
    import bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        accept,
    input  owner_e      busy_owner,
    input  logic [31:0] ram_rdata,
    input  logic [31:0] rom_rdata,
    input  logic [31:0] mmio_rdata,
    output logic        cpu_ready,
    output logic        dbg_ready,
    output bus_rsp_t    cpu_rsp,
    output bus_rsp_t    dbg_rsp
);

    logic        ready_q;
    logic [31:0] merged;

    // unselected banks drive zero, so OR is the merge
    assign merged = ram_rdata | rom_rdata | mmio_rdata;

    // ready lands one cycle after the bank sampled the access
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= accept;
        end
    end

    // only the owner hears the answer
    assign cpu_ready = ready_q && (busy_owner == OWN_CPU);
    assign dbg_ready = ready_q && (busy_owner == OWN_DBG);

    assign cpu_rsp.rdata = cpu_ready ? merged : '0;
    assign dbg_rsp.rdata = dbg_ready ? merged : '0;

    a_ready_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        ready_q |=> !ready_q
    ) else $error("bus_result: ready high on two consecutive cycles");

endmodule

`default_nettype wire

// ==== rvbus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvbus_top
    import map_pkg::*, bus_pkg::*;
#(
    parameter int RAM_WORDS    = 1024,
    parameter int ROM_WORDS    = 1024,
    parameter int PWM_CHANNELS = 3
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cpu_run,
    input  logic                    cpu_valid,
    input  bus_req_t                cpu_req,
    input  logic                    dbg_valid,
    input  bus_req_t                dbg_req,
    output logic                    cpu_ready,
    output bus_rsp_t                cpu_rsp,
    output logic                    dbg_ready,
    output bus_rsp_t                dbg_rsp,
    output logic [PWM_CHANNELS-1:0] pwm_out
);

    bus_req_t    gnt_req;
    logic        accept;
    owner_e      busy_owner;
    sel_t        sel;
    logic        ram_we;
    logic        rom_we;
    logic        mmio_we;
    logic [1:0]  mmio_channel;
    logic [31:0] ram_rdata;
    logic [31:0] rom_rdata;
    logic [31:0] mmio_rdata;

    bus_arbiter arbiter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_run    (cpu_run),
        .cpu_valid  (cpu_valid),
        .dbg_valid  (dbg_valid),
        .cpu_req    (cpu_req),
        .dbg_req    (dbg_req),
        .gnt_req    (gnt_req),
        .accept     (accept),
        .busy_owner (busy_owner)
    );

    bus_decode decode_i (
        .gnt_req      (gnt_req),
        .accept       (accept),
        .sel          (sel),
        .ram_we       (ram_we),
        .rom_we       (rom_we),
        .mmio_we      (mmio_we),
        .mmio_channel (mmio_channel)
    );

    // RAM at 0x00000
    sram_bank #(.DEPTH_WORDS(RAM_WORDS)) ram_i (
        .clk   (clk),
        .cs    (sel.ram),
        .we    (ram_we),
        .wstrb (gnt_req.wstrb),
        .index (gnt_req.addr.mem.index),
        .wdata (gnt_req.wdata),
        .rdata (ram_rdata)
    );

    // ROM at 0x20000, same macro as RAM
    sram_bank #(.DEPTH_WORDS(ROM_WORDS)) rom_i (
        .clk   (clk),
        .cs    (sel.rom),
        .we    (rom_we),
        .wstrb (gnt_req.wstrb),
        .index (gnt_req.addr.mem.index),
        .wdata (gnt_req.wdata),
        .rdata (rom_rdata)
    );

    // PWM channels at 0x10000
    pwm_bank #(.PWM_CHANNELS(PWM_CHANNELS)) pwm_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cs      (sel.mmio),
        .we      (mmio_we),
        .channel (mmio_channel),
        .wdata   (gnt_req.wdata),
        .rdata   (mmio_rdata),
        .pwm_out (pwm_out)
    );

    bus_result result_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .accept     (accept),
        .busy_owner (busy_owner),
        .ram_rdata  (ram_rdata),
        .rom_rdata  (rom_rdata),
        .mmio_rdata (mmio_rdata),
        .cpu_ready  (cpu_ready),
        .dbg_ready  (dbg_ready),
        .cpu_rsp    (cpu_rsp),
        .dbg_rsp    (dbg_rsp)
    );

endmodule

`default_nettype wire

// ==== rvbus_tb_table.svh ====
`ifndef RVBUS_TB_TABLE_SVH
`define RVBUS_TB_TABLE_SVH

// columns: name, master, cpu_run, address, wdata, wstrb, expected rdata, compare rdata
typedef struct {
    string       name;
    owner_e      master;
    logic        run;
    logic [17:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] exp_rdata;
    logic        chk;
} entry_t;

localparam int NUM_ENTRIES = 22;

entry_t stim_table [NUM_ENTRIES] = '{
    '{"ram_full_wr_dbg",  OWN_DBG, 1'b1, 18'h00010, 32'h11223344, 4'hF, 32'h0,        1'b0},
    '{"ram_full_rd_cpu",  OWN_CPU, 1'b1, 18'h00010, 32'h0,        4'h0, 32'h11223344, 1'b1},
    '{"ram_byte1_wr_cpu", OWN_CPU, 1'b1, 18'h00010, 32'hAABBCCDD, 4'h2, 32'h0,        1'b0},
    '{"ram_byte1_rd_dbg", OWN_DBG, 1'b1, 18'h00010, 32'h0,        4'h0, 32'h1122CC44, 1'b1},
    '{"ram_byte3_wr_dbg", OWN_DBG, 1'b1, 18'h00010, 32'h55667788, 4'h8, 32'h0,        1'b0},
    '{"ram_byte3_rd_cpu", OWN_CPU, 1'b1, 18'h00010, 32'h0,        4'h0, 32'h5522CC44, 1'b1},
    '{"ram_full_wr_cpu",  OWN_CPU, 1'b1, 18'h00024, 32'h01020304, 4'hF, 32'h0,        1'b0},
    '{"ram_half_wr_dbg",  OWN_DBG, 1'b1, 18'h00024, 32'hF0E0D0C0, 4'h3, 32'h0,        1'b0},
    '{"ram_half_rd_cpu",  OWN_CPU, 1'b1, 18'h00024, 32'h0,        4'h0, 32'h0102D0C0, 1'b1},
    '{"rom_load_dbg",     OWN_DBG, 1'b1, 18'h20040, 32'hCAFEF00D, 4'hF, 32'h0,        1'b0},
    '{"rom_wr_cpu",       OWN_CPU, 1'b1, 18'h20040, 32'h0BADBEEF, 4'hF, 32'h0,        1'b0},
    '{"rom_rd_cpu",       OWN_CPU, 1'b1, 18'h20040, 32'h0,        4'h0, 32'hCAFEF00D, 1'b1},
    '{"none_wr_dbg",      OWN_DBG, 1'b1, 18'h30000, 32'hFFFFFFFF, 4'hF, 32'h0,        1'b0},
    '{"none_rd_cpu",      OWN_CPU, 1'b1, 18'h30000, 32'h0,        4'h0, 32'h0,        1'b1},
    '{"pwm0_wr_dbg",      OWN_DBG, 1'b1, 18'h10000, 32'h00000010, 4'hF, 32'h0,        1'b0},
    '{"pwm1_wr_dbg",      OWN_DBG, 1'b1, 18'h10004, 32'h12345640, 4'hF, 32'h0,        1'b0},
    '{"pwm2_wr_dbg",      OWN_DBG, 1'b1, 18'h10008, 32'h000000C8, 4'hF, 32'h0,        1'b0},
    '{"pwm3_wr_dbg",      OWN_DBG, 1'b1, 18'h1000C, 32'h00000077, 4'hF, 32'h0,        1'b0},
    '{"pwm0_rd_cpu",      OWN_CPU, 1'b1, 18'h10000, 32'h0,        4'h0, 32'h00000010, 1'b1},
    '{"pwm1_rd_dbg",      OWN_DBG, 1'b1, 18'h10004, 32'h0,        4'h0, 32'h00000040, 1'b1},
    '{"pwm2_rd_cpu",      OWN_CPU, 1'b1, 18'h10008, 32'h0,        4'h0, 32'h000000C8, 1'b1},
    '{"pwm3_rd_dbg",      OWN_DBG, 1'b1, 18'h1000C, 32'h0,        4'h0, 32'h0,        1'b1}
};

`endif

// ==== rvbus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvbus_tb
    import map_pkg::*, bus_pkg::*;
;

    localparam int PWM_CHANNELS = 3;

    `include "rvbus_tb_table.svh"

    localparam int CYCLE_LIMIT = NUM_ENTRIES * 10 + PWM_CHANNELS * 600 + 200;

    logic                    clk;
    logic                    rst_n;
    logic                    cpu_run;
    logic                    cpu_valid;
    bus_req_t                cpu_req;
    logic                    dbg_valid;
    bus_req_t                dbg_req;
    logic                    cpu_ready;
    bus_rsp_t                cpu_rsp;
    logic                    dbg_ready;
    bus_rsp_t                dbg_rsp;
    logic [PWM_CHANNELS-1:0] pwm_out;

    int          errors;
    int          cycles;
    logic        ready_prev;
    logic [31:0] ram_model [int];
    logic [7:0]  duty_model [PWM_CHANNELS];

    rvbus_top #(
        .RAM_WORDS    (1024),
        .ROM_WORDS    (1024),
        .PWM_CHANNELS (PWM_CHANNELS)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_run   (cpu_run),
        .cpu_valid (cpu_valid),
        .cpu_req   (cpu_req),
        .dbg_valid (dbg_valid),
        .dbg_req   (dbg_req),
        .cpu_ready (cpu_ready),
        .cpu_rsp   (cpu_rsp),
        .dbg_ready (dbg_ready),
        .dbg_rsp   (dbg_rsp),
        .pwm_out   (pwm_out)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ready pulses are single cycle and never on both ports
    always @(negedge clk) begin
        if (rst_n) begin
            if (cpu_ready && dbg_ready) begin
                $display("ERROR: ready on both ports at once");
                errors++;
            end
            if ((cpu_ready || dbg_ready) && ready_prev) begin
                $display("ERROR: ready high in two consecutive cycles");
                errors++;
            end
        end
        ready_prev = cpu_ready || dbg_ready;
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wd,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic bus_req_t make_req(input logic [17:0] addr, input logic [31:0] wd,
                                          input logic [3:0] strb, input owner_e who);
        bus_req_t r;
        r.addr  = addr;
        r.wdata = wd;
        r.wstrb = strb;
        r.owner = who;
        return r;
    endfunction

    // track RAM contents and duty registers the way the bus rules define them
    task automatic update_model(input logic [17:0] addr, input logic [31:0] wd,
                                input logic [3:0] strb);
        int idx;
        idx = int'(addr[15:2]);
        if (strb != 4'h0 && addr[17:16] == 2'd0) begin
            if (!ram_model.exists(idx)) begin
                ram_model[idx] = 32'h0;
            end
            ram_model[idx] = merge_bytes(ram_model[idx], wd, strb);
        end
        if (strb != 4'h0 && addr[17:16] == 2'd1 && int'(addr[3:2]) < PWM_CHANNELS) begin
            duty_model[addr[3:2]] = wd[7:0];
        end
    endtask

    // one access from one master and a latency check while run is high
    task automatic do_access(input string name, input owner_e who, input logic run,
                             input logic [17:0] addr, input logic [31:0] wd,
                             input logic [3:0] strb, output logic [31:0] rd);
        int n;
        n = 0;
        @(posedge clk);
        cpu_run <= run;
        if (who == OWN_DBG) begin
            dbg_valid <= 1'b1;
            dbg_req   <= make_req(addr, wd, strb, who);
        end else begin
            cpu_valid <= 1'b1;
            cpu_req   <= make_req(addr, wd, strb, who);
        end
        forever begin
            @(negedge clk);
            n++;
            if ((who == OWN_DBG && cpu_ready) || (who == OWN_CPU && dbg_ready)) begin
                $display("ERROR: %s got ready on the wrong port", name);
                errors++;
            end
            if (who == OWN_DBG && dbg_ready) begin
                rd = dbg_rsp.rdata;
                break;
            end
            if (who == OWN_CPU && cpu_ready) begin
                rd = cpu_rsp.rdata;
                break;
            end
        end
        if (run && n != 2) begin
            $display("ERROR: %s ready came after %0d cycles instead of 2", name, n);
            errors++;
        end
        @(posedge clk);
        dbg_valid <= 1'b0;
        cpu_valid <= 1'b0;
        update_model(addr, wd, strb);
    endtask

    // both masters raise valid on the same edge
    task automatic contend(input string name, input logic [17:0] d_addr, input logic [31:0] d_wd,
                           input logic [3:0] d_strb, input logic [17:0] c_addr,
                           input logic [31:0] c_wd, input logic [3:0] c_strb,
                           output logic [31:0] d_rd, output logic [31:0] c_rd);
        logic d_done;
        logic c_done;
        d_done = 1'b0;
        c_done = 1'b0;
        @(posedge clk);
        cpu_run   <= 1'b1;
        dbg_valid <= 1'b1;
        dbg_req   <= make_req(d_addr, d_wd, d_strb, OWN_DBG);
        cpu_valid <= 1'b1;
        cpu_req   <= make_req(c_addr, c_wd, c_strb, OWN_CPU);
        while (!(d_done && c_done)) begin
            @(negedge clk);
            if (dbg_ready) begin
                d_rd   = dbg_rsp.rdata;
                d_done = 1'b1;
            end
            if (cpu_ready) begin
                if (!d_done) begin
                    $display("ERROR: %s cpu access finished before the debug access", name);
                    errors++;
                end
                c_rd   = cpu_rsp.rdata;
                c_done = 1'b1;
            end
            @(posedge clk);
            if (d_done) begin
                dbg_valid <= 1'b0;
            end
            if (c_done) begin
                cpu_valid <= 1'b0;
            end
        end
        update_model(d_addr, d_wd, d_strb);
        update_model(c_addr, c_wd, c_strb);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] rd2;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] exp_old;
        int          high_cnt;

        clk        = 1'b0;
        rst_n      = 1'b0;
        cpu_run    = 1'b0;
        cpu_valid  = 1'b0;
        dbg_valid  = 1'b0;
        cpu_req    = '0;
        dbg_req    = '0;
        errors     = 0;
        cycles     = 0;
        ready_prev = 1'b0;
        for (int k = 0; k < PWM_CHANNELS; k++) begin
            duty_model[k] = 8'h0;
        end
        void'($urandom(20));

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        foreach (stim_table[i]) begin
            do_access(stim_table[i].name, stim_table[i].master, stim_table[i].run,
                      stim_table[i].addr, stim_table[i].wdata, stim_table[i].wstrb, rd);
            if (stim_table[i].chk) begin
                check_val(stim_table[i].name, stim_table[i].exp_rdata, rd);
            end
        end

        // debug write races a CPU read and then the other way round
        w1      = $urandom;
        w2      = $urandom;
        exp_old = ram_model[4];
        contend("race_a", 18'h00100, w1, 4'hF, 18'h00010, 32'h0, 4'h0, rd, rd2);
        check_val("race_a_cpu_rd", exp_old, rd2);
        contend("race_b", 18'h00100, 32'h0, 4'h0, 18'h00104, w2, 4'hF, rd, rd2);
        check_val("race_b_dbg_rd", ram_model[64], rd);
        do_access("race_b_chk", OWN_DBG, 1'b1, 18'h00104, 32'h0, 4'h0, rd);
        check_val("race_b_chk", ram_model[65], rd);

        // halted CPU stays waiting until cpu_run rises
        @(posedge clk);
        cpu_run   <= 1'b0;
        cpu_valid <= 1'b1;
        cpu_req   <= make_req(18'h00024, 32'h0, 4'h0, OWN_CPU);
        repeat (6) begin
            @(negedge clk);
            if (cpu_ready) begin
                $display("ERROR: cpu got ready while cpu_run was low");
                errors++;
            end
        end
        do_access("halted_cpu_rd", OWN_CPU, 1'b1, 18'h00024, 32'h0, 4'h0, rd);
        check_val("halted_cpu_rd", ram_model[9], rd);

        // one full PWM period per channel
        for (int k = 0; k < PWM_CHANNELS; k++) begin
            high_cnt = 0;
            repeat (256) begin
                @(negedge clk);
                if (pwm_out[k]) begin
                    high_cnt++;
                end
            end
            check_val($sformatf("pwm%0d_high_cycles", k), 32'(duty_model[k]), 32'(high_cnt));
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rvbus_soc.f ====
+incdir+.
map_pkg.sv
bus_pkg.sv
bus_arbiter.sv
bus_decode.sv
sram_bank.sv
pwm_bank.sv
bus_result.sv
rvbus_top.sv
rvbus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rvbus testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f rvbus_soc.f \
    --top-module rvbus_tb \
    --Mdir obj_dir \
    -o rvbus_sim

./obj_dir/rvbus_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
else
    exit 1
fi
